// File: rtl/dcache_defines.svh
// ****************************************
// data cache geometry and field widths
// ****************************************
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// 32-bit address = tag | index | offset
`define DCACHE_ADDR_W    32
`define DCACHE_LINE_W    64
`define DCACHE_TAG_W     23
`define DCACHE_INDEX_W   6
`define DCACHE_OFFSET_W  3

`define DCACHE_LINES     64    // direct mapped, 8 bytes each

// memory tag 0 means no transaction
`define DCACHE_MEM_TAG_W 4
`define DCACHE_SLOTS     15    // one miss slot per nonzero tag

`endif

// File: rtl/dcache_pkg.sv
// ****************************************
// data cache shared types
// ****************************************
`include "dcache_defines.svh"

package dcache_pkg;

    // command on both the processor and memory side
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_command_t;

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_t;

    typedef logic [`DCACHE_LINE_W-1:0] line_t;       // one cache line
    typedef logic [`DCACHE_MEM_TAG_W-1:0] mem_tag_t;

endpackage

// File: rtl/store_merge.sv
// ****************************************
// store merge: drops a sub-line store into
// an 8-byte line by size and offset
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module store_merge (
    input  dcache_pkg::line_t          line_in,
    input  logic [`DCACHE_OFFSET_W-1:0] offset,
    input  dcache_pkg::mem_size_t      size,
    input  logic [`DCACHE_LINE_W-1:0]  store_data,
    output dcache_pkg::line_t          line_out
);

    always_comb begin
        line_out = line_in;  // untouched bytes pass through
        case (size)
            dcache_pkg::SIZE_BYTE: begin
                line_out[{offset, 3'b000} +: 8] = store_data[7:0];
            end
            dcache_pkg::SIZE_HALF: begin
                line_out[{offset[2:1], 4'b0000} +: 16] = store_data[15:0];
            end
            dcache_pkg::SIZE_WORD: begin
                line_out[{offset[2], 5'b00000} +: 32] = store_data[31:0];
            end
            default: begin
                line_out = store_data;  // double covers the whole line
            end
        endcase
    end

endmodule

// File: rtl/cache_array.sv
// ****************************************
// cache array: tag, valid, dirty and data
// for 64 lines, one lookup, one write port
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module cache_array (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`DCACHE_ADDR_W-1:0]  lookup_addr,
    output logic                       lookup_hit,
    output dcache_pkg::line_t          lookup_line,
    input  logic                       wr_en,
    input  logic [`DCACHE_INDEX_W-1:0] wr_index,
    input  logic [`DCACHE_TAG_W-1:0]   wr_tag,
    input  dcache_pkg::line_t          wr_line,
    input  logic                       wr_dirty,
    input  logic [`DCACHE_INDEX_W-1:0] victim_index,
    output logic                       victim_valid,
    output logic                       victim_dirty,
    output logic [`DCACHE_TAG_W-1:0]   victim_tag,
    output dcache_pkg::line_t          victim_line,
    input  logic                       store_hit_en,
    input  dcache_pkg::line_t          store_hit_line
);

    logic [`DCACHE_TAG_W-1:0]   tag_mem [`DCACHE_LINES];
    dcache_pkg::line_t          data_mem [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0]   valid;
    logic [`DCACHE_LINES-1:0]   dirty;
    logic [`DCACHE_INDEX_W-1:0] lookup_index;
    logic [`DCACHE_TAG_W-1:0]   lookup_tag;

    assign lookup_index = lookup_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign lookup_tag   = lookup_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    assign lookup_hit  = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign lookup_line = data_mem[lookup_index];

    // line a fill is about to replace
    assign victim_valid = valid[victim_index];
    assign victim_dirty = dirty[victim_index];
    assign victim_tag   = tag_mem[victim_index];
    assign victim_line  = data_mem[victim_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (wr_en) begin  // fill wins over a store hit
            valid[wr_index] <= 1'b1;
            dirty[wr_index] <= wr_dirty;
        end else if (store_hit_en) begin
            dirty[lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_line;
        end else if (store_hit_en) begin
            data_mem[lookup_index] <= store_hit_line;  // tag unchanged on a hit
        end
    end

endmodule

// File: rtl/miss_slot.sv
// ****************************************
// miss slot: one outstanding miss, held
// from allocation until its fill retires
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module miss_slot (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      alloc,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  dcache_pkg::mem_size_t     req_size,
    input  dcache_pkg::line_t         req_data,
    input  logic                      req_is_store,
    input  logic                      retire,
    input  logic [`DCACHE_ADDR_W-1:0] probe_addr,
    output logic                      slot_valid,
    output logic [`DCACHE_ADDR_W-1:0] slot_addr,
    output dcache_pkg::mem_size_t     slot_size,
    output dcache_pkg::line_t         slot_data,
    output logic                      slot_is_store,
    output logic                      slot_match
);

    // a tag can be retired and handed out again on the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (alloc) begin
            slot_valid <= 1'b1;
        end else if (retire) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_addr     <= req_addr;  // full address, offset is needed by the merge
            slot_size     <= req_size;
            slot_data     <= req_data;
            slot_is_store <= req_is_store;
        end
    end

    // compare line addresses only
    assign slot_match = slot_valid &&
        (slot_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W] ==
         probe_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]);

endmodule

// File: rtl/miss_control.sv
// ****************************************
// miss control: idle/miss FSM, reports hits
// and issues line loads for misses
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module miss_control (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_pkg::bus_command_t   proc_command,
    input  logic [`DCACHE_ADDR_W-1:0]  proc_addr,
    input  logic                       lookup_hit,
    input  logic                       any_match,
    input  logic                       fill_busy,
    input  logic                       evict_pending,
    input  dcache_pkg::mem_tag_t       mem_response,
    output logic                       mem_load,
    output logic [`DCACHE_ADDR_W-1:0]  load_addr,
    output logic                       alloc_valid,
    output dcache_pkg::mem_tag_t       alloc_tag,
    output dcache_pkg::mem_tag_t       resp_tag,
    output logic                       hit,
    output logic                       store_hit_en
);

    typedef enum logic {
        IDLE = 1'b0,
        MISS = 1'b1
    } state_t;

    state_t state;
    state_t state_next;
    logic   request;
    logic   hit_next;
    logic   accept;

    assign request = (proc_command != dcache_pkg::BUS_NONE);

    // no hits while a fill owns the array
    assign hit_next     = (state == IDLE) && request && lookup_hit && !fill_busy;
    assign store_hit_en = hit_next && (proc_command == dcache_pkg::BUS_STORE);

    // eviction store has the bus first
    assign mem_load  = (state == MISS) && !evict_pending;
    assign load_addr = {proc_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                        {`DCACHE_OFFSET_W{1'b0}}};
    assign accept    = mem_load && (mem_response != '0);

    assign alloc_valid = accept;
    assign alloc_tag   = mem_response;  // memory picks the tag and so the slot

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // an outstanding line stalls instead of reissuing
                if (request && !lookup_hit && !any_match && !evict_pending) begin
                    state_next = MISS;
                end
            end
            MISS: begin
                if (accept) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            hit      <= 1'b0;
            resp_tag <= '0;
        end else begin
            state    <= state_next;
            hit      <= hit_next;
            resp_tag <= accept ? mem_response : '0;  // one cycle per acceptance
        end
    end

endmodule

// File: rtl/fill_unit.sv
// ****************************************
// fill unit: writes returning lines, merges
// store misses, captures dirty victims
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module fill_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_pkg::mem_tag_t       mem_tag,
    input  dcache_pkg::line_t          mem_rdata,
    input  dcache_pkg::line_t          lookup_line,
    input  logic [`DCACHE_SLOTS:1]     slot_valid,
    input  logic [`DCACHE_ADDR_W-1:0]  slot_addr [1:`DCACHE_SLOTS],
    input  dcache_pkg::mem_size_t      slot_size [1:`DCACHE_SLOTS],
    input  dcache_pkg::line_t          slot_data [1:`DCACHE_SLOTS],
    input  logic [`DCACHE_SLOTS:1]     slot_is_store,
    input  logic                       victim_valid,
    input  logic                       victim_dirty,
    input  logic [`DCACHE_TAG_W-1:0]   victim_tag,
    input  dcache_pkg::line_t          victim_line,
    output logic [`DCACHE_SLOTS:1]     retire,
    output logic                       fill_busy,
    output logic [`DCACHE_INDEX_W-1:0] victim_index,
    output logic                       wr_en,
    output logic [`DCACHE_INDEX_W-1:0] wr_index,
    output logic [`DCACHE_TAG_W-1:0]   wr_tag,
    output dcache_pkg::line_t          wr_line,
    output logic                       wr_dirty,
    output logic                       evict_pending,
    output logic [`DCACHE_ADDR_W-1:0]  evict_addr,
    output dcache_pkg::line_t          evict_line,
    output dcache_pkg::line_t          hit_data,
    output dcache_pkg::mem_tag_t       data_tag
);

    logic                      fill;
    logic                      fill_store;
    logic [`DCACHE_ADDR_W-1:0] fill_addr;
    dcache_pkg::line_t         merged_line;

    assign fill       = (mem_tag != '0) && slot_valid[mem_tag];  // tag 0 returns nothing
    assign fill_store = fill && slot_is_store[mem_tag];
    assign fill_addr  = slot_addr[mem_tag];
    assign fill_busy  = fill;

    // store miss bytes land on top of the returned line
    store_merge u_merge (
        .line_in    (mem_rdata),
        .offset     (fill_addr[`DCACHE_OFFSET_W-1:0]),
        .size       (slot_size[mem_tag]),
        .store_data (slot_data[mem_tag]),
        .line_out   (merged_line)
    );

    always_comb begin
        for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
            retire[i] = fill && (mem_tag == dcache_pkg::mem_tag_t'(i));
        end
    end

    assign victim_index = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign wr_en        = fill;
    assign wr_index     = victim_index;
    assign wr_tag       = fill_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign wr_line      = fill_store ? merged_line : mem_rdata;
    assign wr_dirty     = fill_store;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            evict_pending <= 1'b0;
            data_tag      <= '0;
        end else begin
            evict_pending <= fill && victim_valid && victim_dirty;  // store goes out next cycle
            data_tag      <= (fill && !fill_store) ? mem_tag : '0;
        end
    end

    always_ff @(posedge clk) begin
        hit_data <= fill ? mem_rdata : lookup_line;
        if (fill) begin
            evict_addr <= {victim_tag, victim_index, {`DCACHE_OFFSET_W{1'b0}}};
            evict_line <= victim_line;
        end
    end

endmodule

// File: rtl/dcache_top.sv
// ****************************************
// non-blocking direct mapped data cache,
// 64 lines of 8 bytes, write-back
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      reset,
    input  dcache_pkg::bus_command_t  proc_command,
    input  logic [`DCACHE_ADDR_W-1:0] proc_addr,
    input  dcache_pkg::line_t         proc_data,
    input  dcache_pkg::mem_size_t     proc_size,
    output logic                      hit,
    output dcache_pkg::line_t         hit_data,
    output dcache_pkg::mem_tag_t      resp_tag,
    output dcache_pkg::mem_tag_t      data_tag,
    output dcache_pkg::bus_command_t  mem_command,
    output logic [`DCACHE_ADDR_W-1:0] mem_addr,
    output dcache_pkg::line_t         mem_data,
    input  dcache_pkg::mem_tag_t      mem_response,
    input  dcache_pkg::mem_tag_t      mem_tag,
    input  dcache_pkg::line_t         mem_rdata
);

    logic                       lookup_hit;
    dcache_pkg::line_t          lookup_line;
    logic                       store_hit_en;
    dcache_pkg::line_t          store_hit_line;
    logic                       wr_en;
    logic [`DCACHE_INDEX_W-1:0] wr_index;
    logic [`DCACHE_TAG_W-1:0]   wr_tag;
    dcache_pkg::line_t          wr_line;
    logic                       wr_dirty;
    logic [`DCACHE_INDEX_W-1:0] victim_index;
    logic                       victim_valid;
    logic                       victim_dirty;
    logic [`DCACHE_TAG_W-1:0]   victim_tag;
    dcache_pkg::line_t          victim_line;
    logic                       mem_load;
    logic [`DCACHE_ADDR_W-1:0]  load_addr;
    logic                       alloc_valid;
    dcache_pkg::mem_tag_t       alloc_tag;
    logic                       any_match;
    logic                       fill_busy;
    logic                       evict_pending;
    logic [`DCACHE_ADDR_W-1:0]  evict_addr;
    dcache_pkg::line_t          evict_line;
    logic [`DCACHE_SLOTS:1]     retire;
    logic [`DCACHE_SLOTS:1]     slot_valid;
    logic [`DCACHE_SLOTS:1]     slot_is_store;
    logic [`DCACHE_SLOTS:1]     slot_match;
    logic [`DCACHE_ADDR_W-1:0]  slot_addr [1:`DCACHE_SLOTS];
    dcache_pkg::mem_size_t      slot_size [1:`DCACHE_SLOTS];
    dcache_pkg::line_t          slot_data [1:`DCACHE_SLOTS];

    cache_array u_array (
        .clk, .reset,
        .lookup_addr (proc_addr),
        .lookup_hit, .lookup_line,
        .wr_en, .wr_index, .wr_tag, .wr_line, .wr_dirty,
        .victim_index, .victim_valid, .victim_dirty, .victim_tag, .victim_line,
        .store_hit_en, .store_hit_line
    );

    // hit path merge
    store_merge u_hit_merge (
        .line_in    (lookup_line),
        .offset     (proc_addr[`DCACHE_OFFSET_W-1:0]),
        .size       (proc_size),
        .store_data (proc_data),
        .line_out   (store_hit_line)
    );

    miss_control u_ctrl (
        .clk, .reset, .proc_command, .proc_addr,
        .lookup_hit, .any_match, .fill_busy, .evict_pending, .mem_response,
        .mem_load, .load_addr, .alloc_valid, .alloc_tag,
        .resp_tag, .hit, .store_hit_en
    );

    for (genvar i = 1; i <= `DCACHE_SLOTS; i++) begin : g_slot
        miss_slot u_slot (
            .clk, .reset,
            .alloc         (alloc_valid && (alloc_tag == dcache_pkg::mem_tag_t'(i))),
            .req_addr      (proc_addr),
            .req_size      (proc_size),
            .req_data      (proc_data),
            .req_is_store  (proc_command == dcache_pkg::BUS_STORE),
            .retire        (retire[i]),
            .probe_addr    (proc_addr),
            .slot_valid    (slot_valid[i]),
            .slot_addr     (slot_addr[i]),
            .slot_size     (slot_size[i]),
            .slot_data     (slot_data[i]),
            .slot_is_store (slot_is_store[i]),
            .slot_match    (slot_match[i])
        );
    end

    assign any_match = |slot_match;  // request line already outstanding

    fill_unit u_fill (
        .clk, .reset, .mem_tag, .mem_rdata, .lookup_line,
        .slot_valid, .slot_addr, .slot_size, .slot_data, .slot_is_store,
        .victim_valid, .victim_dirty, .victim_tag, .victim_line,
        .retire, .fill_busy, .victim_index,
        .wr_en, .wr_index, .wr_tag, .wr_line, .wr_dirty,
        .evict_pending, .evict_addr, .evict_line, .hit_data, .data_tag
    );

    // write-back beats the pending line load
    always_comb begin
        if (evict_pending) begin
            mem_command = dcache_pkg::BUS_STORE;
        end else if (mem_load) begin
            mem_command = dcache_pkg::BUS_LOAD;
        end else begin
            mem_command = dcache_pkg::BUS_NONE;
        end
    end

    assign mem_addr = evict_pending ? evict_addr : load_addr;
    assign mem_data = evict_line;

endmodule

// File: tb/dcache_assert.sv
// ****************************************
// data cache handshake assertions, bound
// into the top level
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_assert (
    input logic                      clk,
    input logic                      reset,
    input dcache_pkg::bus_command_t  mem_command,
    input logic [`DCACHE_ADDR_W-1:0] mem_addr,
    input dcache_pkg::mem_tag_t      mem_response,
    input dcache_pkg::mem_tag_t      resp_tag,
    input logic                      hit,
    input dcache_pkg::mem_tag_t      data_tag
);

    // a refused line load comes back with the same address
    refused_load_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_command == dcache_pkg::BUS_LOAD && mem_response == '0)
        |=> (mem_command != dcache_pkg::BUS_LOAD || $stable(mem_addr)))
        else $error("line load address changed while memory refused it");

    // each accepted load shows its tag for exactly one cycle
    resp_tag_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (mem_command == dcache_pkg::BUS_LOAD && mem_response != '0)
        |=> (resp_tag == $past(mem_response)) ##1 (resp_tag == '0))
        else $error("resp_tag did not echo the accepted tag for one cycle");

    reset_outputs_quiet: assert property (@(posedge clk)
        reset |-> (!hit && resp_tag == '0 && data_tag == '0))
        else $error("processor output active during reset");

endmodule

bind dcache_top dcache_assert u_assert (.*);

// File: tb/dcache_tb.sv
// ****************************************
// data cache testbench: random processor
// traffic, tagged memory model, byte image
// ****************************************
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_tb;

    localparam int NUM_REQ     = 400;
    localparam int WORST_LAT   = 60;    // per request, refusals and full slots included
    localparam int CYCLE_LIMIT = NUM_REQ * WORST_LAT;
    localparam int MAX_DELAY   = 12;    // fill latency in cycles, at least 2

    logic                      clk;
    logic                      reset;
    dcache_pkg::bus_command_t  proc_command;
    logic [`DCACHE_ADDR_W-1:0] proc_addr;
    dcache_pkg::line_t         proc_data;
    dcache_pkg::mem_size_t     proc_size;
    logic                      hit;
    dcache_pkg::line_t         hit_data;
    dcache_pkg::mem_tag_t      resp_tag;
    dcache_pkg::mem_tag_t      data_tag;
    dcache_pkg::bus_command_t  mem_command;
    logic [`DCACHE_ADDR_W-1:0] mem_addr;
    dcache_pkg::line_t         mem_data;
    dcache_pkg::mem_tag_t      mem_response;
    dcache_pkg::mem_tag_t      mem_tag;
    dcache_pkg::line_t         mem_rdata;

    logic [31:0]       rng_state;
    logic [7:0]        ref_bytes [logic [31:0]];  // expected byte image
    dcache_pkg::line_t backing [logic [31:0]];    // memory model, by line address
    logic              tag_busy  [1:`DCACHE_SLOTS];
    logic [31:0]       tag_addr  [1:`DCACHE_SLOTS];
    int                tag_delay [1:`DCACHE_SLOTS];
    logic              wait_load [1:`DCACHE_SLOTS];  // load accepted, data not back yet
    logic [31:0]       wait_addr [1:`DCACHE_SLOTS];
    logic              req_active;
    int                issued;
    int                cycles;
    int                write_backs;
    int                checks;
    int                value_errors;
    int                protocol_errors;

    dcache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // power-on content, every address bit shows up in the line
    function automatic dcache_pkg::line_t init_line(logic [31:0] line_addr);
        return {line_addr ^ 32'ha5c3_0f1e, ~line_addr + 32'h1357_9bdf};
    endfunction

    function automatic dcache_pkg::line_t memory_line(logic [31:0] line_addr);
        return backing.exists(line_addr) ? backing[line_addr] : init_line(line_addr);
    endfunction

    function automatic dcache_pkg::line_t ref_line(logic [31:0] addr);
        logic [31:0]       base;
        dcache_pkg::line_t line;
        base = {addr[31:3], 3'b000};
        line = init_line(base);
        for (int k = 0; k < 8; k++) begin
            if (ref_bytes.exists(base + k)) begin
                line[8*k +: 8] = ref_bytes[base + k];
            end
        end
        return line;
    endfunction

    // aligned group of 1, 2, 4 or 8 bytes takes the low bytes of the data
    function automatic void ref_store(logic [31:0] addr, dcache_pkg::mem_size_t size,
                                      dcache_pkg::line_t data);
        int          n;
        logic [31:0] first;
        n     = 1 << int'(size);
        first = addr & ~32'(n - 1);
        for (int k = 0; k < n; k++) begin
            ref_bytes[first + k] = data[8*k +: 8];
        end
    endfunction

    // four indices, four tags each, so lines keep evicting one another
    function automatic logic [31:0] pick_addr(dcache_pkg::mem_size_t size);
        logic [31:0] r;
        logic [22:0] tag;
        logic [5:0]  index;
        logic [2:0]  offset;
        r = next_rand();
        case (r[1:0])
            2'd0: index = 6'd5;
            2'd1: index = 6'd22;
            2'd2: index = 6'd41;
            default: index = 6'd63;
        endcase
        tag    = 23'h01a0 + 23'(r[3:2]) * 23'h2b5;
        offset = r[6:4];
        case (size)
            dcache_pkg::SIZE_HALF: offset[0] = 1'b0;
            dcache_pkg::SIZE_WORD: offset[1:0] = 2'b00;
            dcache_pkg::SIZE_DOUBLE: offset = 3'b000;
            default: ;
        endcase
        return {tag, index, offset};
    endfunction

    function automatic logic work_left();
        logic busy;
        busy = (issued < NUM_REQ) || req_active;
        for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
            busy = busy || tag_busy[i] || wait_load[i];
        end
        return busy;
    endfunction

    task automatic check_line(input string what, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t want);
        checks++;
        assert (got == want) else begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", what, got, want);
        end
    endtask

    initial begin : stimulus
        dcache_pkg::mem_tag_t offer;
        dcache_pkg::mem_tag_t last_offer;
        dcache_pkg::mem_tag_t fill_tag;
        logic [31:0]          r;
        int                   idle_left;
        int                   ready;
        int                   k;
        int                   start;
        int                   t;

        rng_state       = 32'hd6a4_faeb;
        reset           = 1'b1;
        proc_command    = dcache_pkg::BUS_NONE;
        proc_addr       = '0;
        proc_data       = '0;
        proc_size       = dcache_pkg::SIZE_BYTE;
        mem_response    = '0;
        mem_tag         = '0;
        mem_rdata       = '0;
        req_active      = 1'b0;
        issued          = 0;
        cycles          = 0;
        write_backs     = 0;
        checks          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        idle_left       = 0;
        last_offer      = '0;
        for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
            tag_busy[i]  = 1'b0;
            tag_addr[i]  = '0;
            tag_delay[i] = 0;
            wait_load[i] = 1'b0;
            wait_addr[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // nothing may move before the first request
        repeat (4) begin
            @(negedge clk);
            checks++;
            assert (!hit && resp_tag == '0 && data_tag == '0 &&
                    mem_command == dcache_pkg::BUS_NONE) else begin
                protocol_errors++;
                $display("outputs active after reset before any request");
            end
        end

        while (work_left() && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;

            if (data_tag != '0) begin  // fill data for an earlier load miss
                checks++;
                assert (wait_load[data_tag]) else begin
                    protocol_errors++;
                    $display("load data returned on tag %0d with no load waiting", data_tag);
                end
                if (wait_load[data_tag]) begin
                    check_line("hit_data", hit_data, ref_line(wait_addr[data_tag]));
                    wait_load[data_tag] = 1'b0;
                end
            end

            if (mem_command == dcache_pkg::BUS_STORE) begin
                checks++;
                assert (mem_addr[2:0] == 3'b000) else begin
                    value_errors++;
                    $display("FAILED mem_addr: got %h, expected a line address", mem_addr);
                end
                check_line("mem_data", mem_data, ref_line(mem_addr));
                backing[{mem_addr[31:3], 3'b000}] = mem_data;
                write_backs++;
            end

            if (hit) begin
                checks++;
                assert (req_active) else begin
                    protocol_errors++;
                    $display("hit raised with no request presented");
                end
                if (req_active) begin
                    if (proc_command == dcache_pkg::BUS_LOAD) begin
                        check_line("hit_data", hit_data, ref_line(proc_addr));
                    end else begin
                        ref_store(proc_addr, proc_size, proc_data);
                    end
                    req_active = 1'b0;
                end
            end else if (resp_tag != '0) begin
                checks++;
                assert (req_active && resp_tag == last_offer) else begin
                    value_errors++;
                    $display("FAILED resp_tag: got %h, expected %h", resp_tag, last_offer);
                end
                if (req_active) begin
                    if (proc_command == dcache_pkg::BUS_LOAD) begin
                        wait_load[resp_tag] = 1'b1;
                        wait_addr[resp_tag] = proc_addr;
                    end else begin
                        ref_store(proc_addr, proc_size, proc_data);  // store done once accepted
                    end
                    req_active = 1'b0;
                end
            end

            // memory model: pick a ready fill first, out of order
            for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
                if (tag_busy[i] && tag_delay[i] > 0) begin
                    tag_delay[i]--;
                end
            end
            fill_tag = '0;
            ready    = 0;
            for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
                if (tag_busy[i] && tag_delay[i] == 0) begin
                    ready++;
                end
            end
            r = next_rand();
            if (ready > 0 && r[1:0] != 2'b00) begin
                k = int'(r[31:8] % ready);
                for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
                    if (tag_busy[i] && tag_delay[i] == 0) begin
                        if (k == 0) begin
                            fill_tag = dcache_pkg::mem_tag_t'(i);
                        end
                        k--;
                    end
                end
            end

            offer = '0;
            if (mem_command == dcache_pkg::BUS_LOAD) begin
                checks++;
                assert (mem_addr[2:0] == 3'b000) else begin
                    value_errors++;
                    $display("FAILED mem_addr: got %h, expected a line address", mem_addr);
                end
                for (int i = 1; i <= `DCACHE_SLOTS; i++) begin
                    assert (!(tag_busy[i] && tag_addr[i] == mem_addr)) else begin
                        protocol_errors++;
                        $display("line load reissued for a line already outstanding");
                    end
                end
                r = next_rand();
                if (r[1:0] != 2'b00) begin  // one load in four is refused
                    start = int'(r[31:8] % `DCACHE_SLOTS);
                    for (int i = 0; i < `DCACHE_SLOTS; i++) begin
                        t = (start + i) % `DCACHE_SLOTS + 1;
                        if (!tag_busy[t] && offer == '0) begin
                            offer = dcache_pkg::mem_tag_t'(t);
                        end
                    end
                    if (offer != '0) begin
                        tag_busy[offer]  = 1'b1;
                        tag_addr[offer]  = mem_addr;
                        tag_delay[offer] = 2 + int'(r[7:4] % (MAX_DELAY - 1));
                    end
                end
            end
            mem_response = offer;
            last_offer   = offer;

            // a returned tag is free again from the next cycle on
            mem_tag = fill_tag;
            if (fill_tag != '0) begin
                mem_rdata          = memory_line(tag_addr[fill_tag]);
                tag_busy[fill_tag] = 1'b0;
            end

            if (!req_active) begin
                proc_command = dcache_pkg::BUS_NONE;
                if (issued < NUM_REQ) begin
                    if (idle_left > 0) begin
                        idle_left--;
                    end else begin
                        r            = next_rand();
                        proc_size    = dcache_pkg::mem_size_t'(r[1:0]);
                        proc_command = r[2] ? dcache_pkg::BUS_STORE : dcache_pkg::BUS_LOAD;
                        proc_addr    = pick_addr(proc_size);
                        proc_data    = {next_rand(), next_rand()};
                        idle_left    = (r[5:3] == 3'd0) ? int'(r[7:6]) + 1 : 0;
                        req_active   = 1'b1;
                        issued++;
                    end
                end
            end
        end

        if (work_left()) begin
            protocol_errors++;
            $display("run stopped at the limit of %0d cycles with requests still open",
                     CYCLE_LIMIT);
        end
        assert (write_backs > 0) else begin
            protocol_errors++;
            $display("no dirty line was written back during the run");
        end
        $display("requests %0d, write-backs %0d, checks %0d, value errors %0d, protocol errors %0d",
                 issued, write_backs, checks, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/store_merge.sv
rtl/cache_array.sv
rtl/miss_slot.sv
rtl/miss_control.sv
rtl/fill_unit.sv
rtl/dcache_top.sv
tb/dcache_assert.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/store_merge.sv
      - rtl/cache_array.sv
      - rtl/miss_slot.sv
      - rtl/miss_control.sv
      - rtl/fill_unit.sv
      - rtl/dcache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/dcache_assert.sv
      - tb/dcache_tb.sv
